/* tb.f */
hw/tcp_seq_pkg.sv
hw/tcp_tx_cfg_pkg.sv
hw/tcp_tx_buf.sv
hw/tcp_pkt_builder.sv
hw/tcp_pkt_table.sv
hw/tcp_rtx_scan.sv
hw/tcp_tx_stream.sv
hw/tcp_tx_ctl.sv
dv/tb_tcp_tx_ctl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_tcp_tx_ctl
RTL_TOP   ?= tcp_tx_ctl
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# status comes from the pass line in the simulator output
run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJDIR)

/* dv/tb_tcp_tx_ctl.sv */
module tb_tcp_tx_ctl;

  localparam int unsigned LFSR_SEED = 58216;
  localparam int FIRST_TMO = 200;  // cycles until a fresh segment goes out
  localparam int RTX_TMO   = 3000; // covers RTO_SCANS sweeps of the whole table
  localparam int CTS_TMO   = 500;
  localparam int VISIT_CYC = 7;    // scanner cycles spent on one table entry
  // cycles from one send of an entry to its retransmission
  localparam int RTO_CYC   = tcp_tx_cfg_pkg::RTO_SCANS * tcp_tx_cfg_pkg::TBL_DEPTH *
                             VISIT_CYC;
  localparam int QUIET_CYC = 2 * RTO_CYC; // window that must stay free of sends

  logic              clk = 1'b0;
  logic              rst_n;
  logic              init;
  tcp_seq_pkg::seq_t init_seq;
  logic              connected;
  logic              in_val;
  logic [7:0]        in_dat;
  logic              in_snd;
  tcp_seq_pkg::seq_t rem_ack;
  logic              req;
  logic              sent;
  logic              cts;
  tcp_seq_pkg::seq_t loc_seq;
  logic              send;
  tcp_seq_pkg::seq_t pld_start;
  tcp_seq_pkg::seq_t pld_stop;
  tcp_seq_pkg::len_t pld_len;
  tcp_seq_pkg::cks_t pld_cks;
  logic              strm_val;
  logic              strm_sof;
  logic              strm_eof;
  logic [7:0]        strm_dat;
  logic              force_dcn;

  logic [15:0]       lfsr = 16'(LFSR_SEED);
  logic [7:0]        wr_log [$];  // bytes since init indexed by seq - base_seq
  tcp_seq_pkg::seq_t base_seq;
  int unsigned       cyc = 0;     // rising edges so far
  int unsigned       last_wr_cyc; // edge that took the latest byte

  always #20 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  tcp_tx_ctl i_dut (.*);

  //////////////////////////////
  // model helpers
  //////////////////////////////

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]}; // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // big-endian words from segment start with a zero low byte padding an odd tail
  function automatic tcp_seq_pkg::cks_t payload_cks(input int unsigned off,
                                                    input int unsigned len);
    tcp_seq_pkg::cks_t sum;
    logic [7:0]        lo;
    sum = '0;
    for (int unsigned i = 0; i < len; i += 2) begin
      lo  = (i + 1 < len) ? wr_log[off + i + 1] : 8'h00;
      sum = sum + {16'h0, wr_log[off + i], lo};
    end
    return sum;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_seq(input string name, input tcp_seq_pkg::seq_t exp,
                           input tcp_seq_pkg::seq_t act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_len(input string name, input tcp_seq_pkg::len_t exp,
                           input tcp_seq_pkg::len_t act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_cks(input string name, input tcp_seq_pkg::cks_t exp,
                           input tcp_seq_pkg::cks_t act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
  endtask

  //////////////////////////////
  // user and engine side
  //////////////////////////////

  task automatic start_conn(input tcp_seq_pkg::seq_t s);
    rem_ack  = s; // nothing acked past the first byte
    init_seq = s;
    init     = 1'b1;
    @(negedge clk);
    init     = 1'b0;
    base_seq = s;
    wr_log.delete();
    check_bit("cts after init", 1'b1, cts);
  endtask

  task automatic write_bytes(input string name, input int n);
    logic [7:0] b;
    int         t;
    for (int i = 0; i < n; i++) begin
      t = 0;
      while (cts !== 1'b1) begin // hold off until the DUT has room
        in_val = 1'b0;
        @(negedge clk);
        t++;
        if (t > CTS_TMO) stop_run($sformatf("%s: cts stayed low, bytes not accepted", name));
      end
      rand_byte(b);
      in_val = 1'b1;
      in_dat = b;
      wr_log.push_back(b);
      last_wr_cyc = cyc + 1; // taken at the coming rising edge
      @(negedge clk);
    end
    in_val = 1'b0;
  endtask

  task automatic pulse_snd();
    in_snd = 1'b1;
    @(negedge clk);
    in_snd = 1'b0;
  endtask

  // engine model waits for send, checks the header, pulses req, collects bytes and pulses sent
  task automatic serve_segment(input string name, input tcp_seq_pkg::seq_t exp_start,
                               input int exp_len, input int tmo, input logic ack,
                               output int unsigned send_cyc);
    tcp_seq_pkg::seq_t exp_stop;
    int unsigned       off;
    int                t;
    exp_stop = exp_start + tcp_seq_pkg::seq_t'(exp_len);
    off      = exp_start - base_seq;
    t        = 0;
    while (send !== 1'b1) begin
      @(negedge clk);
      t++;
      if (t > tmo) stop_run($sformatf("%s: no send within %0d cycles", name, tmo));
    end
    send_cyc = cyc;
    check_seq({name, " start"}, exp_start, pld_start);
    check_seq({name, " stop"}, exp_stop, pld_stop);
    check_len({name, " len"}, tcp_seq_pkg::len_t'(exp_len), pld_len);
    check_cks({name, " cks"}, payload_cks(off, exp_len), pld_cks);
    req = 1'b1;
    @(negedge clk);
    req = 1'b0;
    check_bit({name, " send after req"}, 1'b0, send);
    for (int k = 0; k < exp_len; k++) begin // one byte per cycle
      check_bit({name, " val"}, 1'b1, strm_val);
      check_bit({name, " sof"}, k == 0, strm_sof);
      check_bit({name, " eof"}, k == exp_len - 1, strm_eof);
      check_byte($sformatf("%s byte %0d", name, k), wr_log[off + k], strm_dat);
      if (k < exp_len - 1) @(negedge clk);
    end
    sent = 1'b1;
    @(negedge clk);
    sent = 1'b0;
    check_bit({name, " val after eof"}, 1'b0, strm_val);
    if (ack) rem_ack = exp_stop;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_explicit_send();
    int unsigned c;
    start_conn(32'h1000_0000);
    write_bytes("explicit send", 5);
    pulse_snd();
    check_seq("explicit send loc_seq", 32'h1000_0005, loc_seq);
    serve_segment("explicit send", 32'h1000_0000, 5, FIRST_TMO, 1'b1, c);
  endtask

  task automatic test_max_payload();
    tcp_seq_pkg::seq_t s0;
    int unsigned       c;
    s0 = 32'hFFFF_FFF8; // crosses the seq wrap
    start_conn(s0);
    fork
      write_bytes("max payload", 2 * tcp_tx_cfg_pkg::MAX_PLD + 3);
      begin
        serve_segment("max payload seg 0", s0, tcp_tx_cfg_pkg::MAX_PLD, FIRST_TMO, 1'b1, c);
        serve_segment("max payload seg 1", s0 + tcp_tx_cfg_pkg::MAX_PLD,
                      tcp_tx_cfg_pkg::MAX_PLD, FIRST_TMO, 1'b1, c);
        serve_segment("max payload seg 2", s0 + 2 * tcp_tx_cfg_pkg::MAX_PLD, 3,
                      FIRST_TMO, 1'b1, c);
      end
    join
    // idle wait, then at least one full scanner visit of the new entry
    if (c - last_wr_cyc < tcp_tx_cfg_pkg::WAIT_TICKS + VISIT_CYC) begin
      stop_run("max payload: tail segment went out before the idle time ran out");
    end
  endtask

  task automatic test_ack_frees();
    tcp_seq_pkg::seq_t s0;
    int unsigned       c;
    int                t;
    s0 = 32'h0000_4000;
    start_conn(s0);
    fork
      begin
        for (int i = 0; i < tcp_tx_cfg_pkg::TBL_DEPTH; i++) begin
          write_bytes("ack frees", 4);
          pulse_snd();
        end
      end
      begin
        for (int i = 0; i < tcp_tx_cfg_pkg::TBL_DEPTH; i++) begin
          serve_segment($sformatf("ack frees seg %0d", i), s0 + 4 * i, 4,
                        FIRST_TMO, 1'b0, c);
        end
      end
    join
    check_bit("ack frees cts with table full", 1'b0, cts);
    rem_ack = s0 + 4 * tcp_tx_cfg_pkg::TBL_DEPTH; // covers every segment
    t = 0;
    while (cts !== 1'b1) begin
      @(negedge clk);
      t++;
      if (t > CTS_TMO) stop_run("ack frees: cts did not come back after the ack");
    end
    for (int i = 0; i < QUIET_CYC; i++) begin
      if (send === 1'b1) stop_run("ack frees: an acked segment was sent again");
      @(negedge clk);
    end
  endtask

  task automatic test_retransmit();
    tcp_seq_pkg::seq_t s0;
    int unsigned       c0;
    int unsigned       c1;
    s0 = 32'h7FFF_FFFE;
    start_conn(s0);
    write_bytes("retransmit", 6);
    pulse_snd();
    serve_segment("retransmit first", s0, 6, FIRST_TMO, 1'b0, c0);
    serve_segment("retransmit again", s0, 6, RTX_TMO, 1'b0, c1); // same header and bytes
    if (c1 - c0 < RTO_CYC) begin
      stop_run("retransmit: segment resent before its timer ran out");
    end
  endtask

  task automatic test_force_dcn();
    tcp_seq_pkg::seq_t s0;
    int unsigned       c;
    int                t;
    s0 = 32'h2000_0100;
    start_conn(s0);
    write_bytes("force dcn", 7);
    pulse_snd();
    for (int i = 0; i < tcp_tx_cfg_pkg::RTX_TRIES; i++) begin
      check_bit("force dcn before last try", 1'b0, force_dcn);
      serve_segment($sformatf("force dcn send %0d", i), s0, 7,
                    (i == 0) ? FIRST_TMO : RTX_TMO, 1'b0, c);
    end
    t = 0;
    while (force_dcn !== 1'b1) begin
      @(negedge clk);
      t++;
      if (t > RTX_TMO) stop_run("force dcn: force_dcn never rose after the last try");
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n     = 1'b0;
    init      = 1'b0;
    init_seq  = '0;
    connected = 1'b0;
    in_val    = 1'b0;
    in_dat    = '0;
    in_snd    = 1'b0;
    rem_ack   = '0;
    req       = 1'b0;
    sent      = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_bit("send after reset", 1'b0, send);
    check_bit("strm_val after reset", 1'b0, strm_val);
    check_bit("strm_sof after reset", 1'b0, strm_sof);
    check_bit("strm_eof after reset", 1'b0, strm_eof);
    check_bit("force_dcn after reset", 1'b0, force_dcn);
    check_bit("cts while not connected", 1'b0, cts);
    connected = 1'b1;
    test_explicit_send();
    test_max_payload();
    test_ack_frees();
    test_retransmit();
    test_force_dcn();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* hw/tcp_tx_ctl.sv */
module tcp_tx_ctl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              init,
  input  tcp_seq_pkg::seq_t init_seq,
  input  logic              connected,
  input  logic              in_val,
  input  logic [7:0]        in_dat,
  input  logic              in_snd,
  input  tcp_seq_pkg::seq_t rem_ack,
  input  logic              req,
  input  logic              sent,
  output logic              cts,
  output tcp_seq_pkg::seq_t loc_seq,
  output logic              send,
  output tcp_seq_pkg::seq_t pld_start,
  output tcp_seq_pkg::seq_t pld_stop,
  output tcp_seq_pkg::len_t pld_len,
  output tcp_seq_pkg::cks_t pld_cks,
  output logic              strm_val,
  output logic              strm_sof,
  output logic              strm_eof,
  output logic [7:0]        strm_dat,
  output logic              force_dcn
);

  logic                              full, tbl_full, add_busy;
  logic                              tbl_wr, b_wr;
  logic [tcp_tx_cfg_pkg::TBL_AW-1:0] tbl_addr, b_addr;
  tcp_seq_pkg::pkt_entry_t           tbl_entry, b_dat, b_q;
  tcp_seq_pkg::seq_t                 free_ack, tx_start_seq, tx_stop;
  tcp_seq_pkg::len_t                 tx_len;
  tcp_seq_pkg::cks_t                 tx_cks;
  logic                              tx_start, tx_idle;
  logic [tcp_tx_cfg_pkg::BUF_AW-1:0] rd_addr;
  logic [7:0]                        rd_dat;

  //////////////////////////////
  // user side
  //////////////////////////////

  tcp_tx_buf i_buf (
    .clk, .rst_n, .init,
    .wr (in_val), .wr_dat (in_dat), .wr_seq (loc_seq), .free_ack,
    .rd_addr, .rd_dat, .full
  );

  tcp_pkt_builder i_bld (
    .clk, .rst_n, .init, .init_seq, .in_val, .in_dat, .in_snd,
    .full, .tbl_full, .connected, .cts, .loc_seq, .add_busy,
    .tbl_wr, .tbl_addr, .tbl_entry
  );

  tcp_pkt_table i_tbl (
    .clk, .a_wr (tbl_wr), .a_addr (tbl_addr), .a_dat (tbl_entry),
    .b_wr, .b_addr, .b_dat, .b_q
  );

  //////////////////////////////
  // engine side
  //////////////////////////////

  tcp_rtx_scan i_scan (
    .clk, .rst_n, .init, .add_busy, .tbl_wr_a (tbl_wr), .rem_ack, .tx_idle,
    .b_wr, .b_addr, .b_dat, .b_q, .tbl_full, .free_ack,
    .tx_start, .tx_start_seq, .tx_stop, .tx_len, .tx_cks, .force_dcn
  );

  tcp_tx_stream i_strm (
    .clk, .rst_n, .init, .init_seq,
    .tx_start, .tx_start_seq, .tx_stop, .tx_len, .tx_cks,
    .req, .sent, .tx_idle, .send, .pld_start, .pld_stop, .pld_len, .pld_cks,
    .rd_addr, .rd_dat, .strm_val, .strm_sof, .strm_eof, .strm_dat
  );

endmodule

/* hw/tcp_tx_stream.sv */
module tcp_tx_stream (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              init,
  input  tcp_seq_pkg::seq_t                 init_seq,
  input  logic                              tx_start,
  input  tcp_seq_pkg::seq_t                 tx_start_seq,
  input  tcp_seq_pkg::seq_t                 tx_stop,
  input  tcp_seq_pkg::len_t                 tx_len,
  input  tcp_seq_pkg::cks_t                 tx_cks,
  input  logic                              req,
  input  logic                              sent,
  output logic                              tx_idle,
  output logic                              send,
  output tcp_seq_pkg::seq_t                 pld_start,
  output tcp_seq_pkg::seq_t                 pld_stop,
  output tcp_seq_pkg::len_t                 pld_len,
  output tcp_seq_pkg::cks_t                 pld_cks,
  output logic [tcp_tx_cfg_pkg::BUF_AW-1:0] rd_addr,
  input  logic [7:0]                        rd_dat,
  output logic                              strm_val,
  output logic                              strm_sof,
  output logic                              strm_eof,
  output logic [7:0]                        strm_dat
);

  typedef enum logic [1:0] {st_idle, st_wait, st_on} st_t;

  st_t               st;
  tcp_seq_pkg::len_t cnt; // index of byte now on strm_dat, from 1

  assign tx_idle  = (st == st_idle);
  assign strm_dat = rd_dat; // buffer read lags address by one cycle

  // payload info held for the engine until the next start
  always_ff @(posedge clk) begin
    if (tx_start) begin
      pld_start <= tx_start_seq;
      pld_stop  <= tx_stop;
      pld_len   <= tx_len;
      pld_cks   <= tx_cks;
    end
  end

  //////////////////////////////
  // engine handshake
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st       <= st_idle;
      send     <= 1'b0;
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      strm_eof <= 1'b0;
      cnt      <= '0;
      rd_addr  <= '0;
    end else if (init) begin
      st       <= st_idle;
      send     <= 1'b0;
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      strm_eof <= 1'b0;
      cnt      <= '0;
      rd_addr  <= init_seq[tcp_tx_cfg_pkg::BUF_AW-1:0];
    end else begin
      case (st)
        st_idle: if (tx_start) begin
          rd_addr <= tx_start_seq[tcp_tx_cfg_pkg::BUF_AW-1:0]; // prefetch first byte
          send    <= 1'b1;
          st      <= st_wait;
        end
        st_wait: if (req) begin
          send     <= 1'b0;
          strm_val <= 1'b1;
          strm_sof <= 1'b1;
          strm_eof <= (pld_len == 1); // single byte segment
          cnt      <= 16'd1;
          rd_addr  <= rd_addr + 1'b1;
          st       <= st_on;
        end
        st_on: begin
          strm_sof <= 1'b0;
          if (strm_eof) begin
            strm_val <= 1'b0; // stream done, wait for sent
            strm_eof <= 1'b0;
          end else if (strm_val) begin
            cnt      <= cnt + 1'b1;
            rd_addr  <= rd_addr + 1'b1;
            strm_eof <= (cnt + 1'b1 == pld_len);
          end
          if (sent) st <= st_idle; // engine finished the frame
        end
        default: st <= st_idle;
      endcase
    end
  end

  a_flags_need_val: assert property (
    @(posedge clk) disable iff (!rst_n) (strm_sof || strm_eof) |-> strm_val
  );

endmodule

/* hw/tcp_rtx_scan.sv */
module tcp_rtx_scan (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              init,
  input  logic                              add_busy,
  input  logic                              tbl_wr_a,
  input  tcp_seq_pkg::seq_t                 rem_ack,
  input  logic                              tx_idle,
  output logic                              b_wr,
  output logic [tcp_tx_cfg_pkg::TBL_AW-1:0] b_addr,
  output tcp_seq_pkg::pkt_entry_t           b_dat,
  input  tcp_seq_pkg::pkt_entry_t           b_q,
  output logic                              tbl_full,
  output tcp_seq_pkg::seq_t                 free_ack,
  output logic                              tx_start,
  output tcp_seq_pkg::seq_t                 tx_start_seq,
  output tcp_seq_pkg::seq_t                 tx_stop,
  output tcp_seq_pkg::len_t                 tx_len,
  output tcp_seq_pkg::cks_t                 tx_cks,
  output logic                              force_dcn
);

  typedef enum logic [2:0] {
    st_latch, st_cmp, st_choose, st_upd, st_wr, st_adv, st_read
  } st_t;

  st_t                               st;
  logic [tcp_tx_cfg_pkg::TBL_AW:0]   add_ptr, rem_ptr, used_cnt; // extra bit tells full
  logic [tcp_tx_cfg_pkg::TBL_AW-1:0] vis_ptr;  // entry being visited
  logic [tcp_tx_cfg_pkg::TBL_AW-1:0] next_ptr; // next entry for first send
  tcp_seq_pkg::pkt_entry_t           ent;      // working copy of visited entry
  tcp_seq_pkg::seq_t                 ack_dif;
  logic live, acked, rto_hit, in_order; // per visit decisions
  logic free, tx;

  assign used_cnt = add_ptr - rem_ptr;
  assign tbl_full = int'(used_cnt) + int'(tbl_wr_a) >= tcp_tx_cfg_pkg::TBL_DEPTH;
  assign b_addr   = vis_ptr;
  assign b_dat    = ent;
  assign tx_start_seq = ent.start; // stable through tx_start
  assign tx_stop      = ent.stop;
  assign tx_len       = ent.len;
  assign tx_cks       = ent.cks;

  //////////////////////////////
  // per visit datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    case (st)
      // slot in the live window, judged before any write at this edge
      st_read:  live <= {1'b0, vis_ptr - rem_ptr[tcp_tx_cfg_pkg::TBL_AW-1:0]} < used_cnt;
      st_latch: begin
        ent     <= b_q;
        ack_dif <= rem_ack - b_q.stop; // sign set while still unacked
      end
      st_cmp: begin
        live     <= live && ent.exists;
        acked    <= !ack_dif[31];
        rto_hit  <= ent.rto >= tcp_tx_cfg_pkg::RTO_SCANS;
        in_order <= (ent.tries != 0) || (vis_ptr == next_ptr); // first sends in order
      end
      st_upd: begin
        if (!add_busy) begin
          if (free) begin
            ent.exists <= 1'b0;
          end else if (tx) begin
            ent.tries <= ent.tries + 1'b1;
            ent.rto   <= '0; // timer restarts on each send
          end else if (!rto_hit) begin
            ent.rto <= ent.rto + 1'b1;
          end
        end
      end
      default: ;
    endcase
  end

  //////////////////////////////
  // scan fsm
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st        <= st_read;
      add_ptr   <= '0;
      rem_ptr   <= '0;
      vis_ptr   <= '0;
      next_ptr  <= '0;
      b_wr      <= 1'b0;
      tx_start  <= 1'b0;
      free      <= 1'b0;
      tx        <= 1'b0;
      force_dcn <= 1'b0;
      free_ack  <= '0;
    end else if (init) begin
      st        <= st_read;
      add_ptr   <= '0;
      rem_ptr   <= '0;
      vis_ptr   <= '0;
      next_ptr  <= '0;
      b_wr      <= 1'b0;
      tx_start  <= 1'b0;
      free      <= 1'b0;
      tx        <= 1'b0;
      force_dcn <= 1'b0;
      free_ack  <= rem_ack; // nothing owed yet
    end else begin
      if (tbl_wr_a) add_ptr <= add_ptr + 1'b1;
      case (st)
        st_read:   st <= st_latch;
        st_latch:  st <= st_cmp;
        st_cmp:    st <= st_choose;
        st_choose: begin
          // only the oldest entry may release buffer space
          free <= live && acked && (vis_ptr == rem_ptr[tcp_tx_cfg_pkg::TBL_AW-1:0]);
          tx   <= live && !acked && rto_hit && in_order && tx_idle &&
                  (ent.tries < tcp_tx_cfg_pkg::RTX_TRIES);
          if (live && !acked && rto_hit && ent.tries >= tcp_tx_cfg_pkg::RTX_TRIES) begin
            force_dcn <= 1'b1; // sticky until init
          end
          st <= st_upd;
        end
        st_upd: begin
          if (!add_busy) begin // builder owns the next cycle
            b_wr     <= live;
            tx_start <= tx;
            if (free) begin
              rem_ptr  <= rem_ptr + 1'b1;
              free_ack <= ent.stop;
            end
            if (tx && ent.tries == 0) next_ptr <= vis_ptr + 1'b1;
            st <= st_wr;
          end
        end
        st_wr: begin
          b_wr     <= 1'b0;
          tx_start <= 1'b0;
          st       <= st_adv;
        end
        st_adv: begin
          vis_ptr <= vis_ptr + 1'b1;
          st      <= st_read;
        end
        default: st <= st_read;
      endcase
    end
  end

endmodule

/* hw/tcp_pkt_table.sv */
module tcp_pkt_table (
  input  logic                              clk,
  input  logic                              a_wr,
  input  logic [tcp_tx_cfg_pkg::TBL_AW-1:0] a_addr,
  input  tcp_seq_pkg::pkt_entry_t           a_dat,
  input  logic                              b_wr,
  input  logic [tcp_tx_cfg_pkg::TBL_AW-1:0] b_addr,
  input  tcp_seq_pkg::pkt_entry_t           b_dat,
  output tcp_seq_pkg::pkt_entry_t           b_q
);

  tcp_seq_pkg::pkt_entry_t mem [tcp_tx_cfg_pkg::TBL_DEPTH];

  //////////////////////////////
  // true dual port
  //////////////////////////////

  // a: builder adds new entries
  // b: scanner reads, updates and frees
  always_ff @(posedge clk) begin
    if (a_wr) mem[a_addr] <= a_dat;
    if (b_wr) mem[b_addr] <= b_dat;
    b_q <= mem[b_addr]; // read first, old contents on a write
  end

  // builder only fills empty slots and scanner only writes back live ones
  a_no_same_addr: assert property (
    @(posedge clk) !(a_wr && b_wr && (a_addr == b_addr))
  );

endmodule

/* hw/tcp_pkt_builder.sv */
module tcp_pkt_builder (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              init,
  input  tcp_seq_pkg::seq_t                 init_seq,
  input  logic                              in_val,
  input  logic [7:0]                        in_dat,
  input  logic                              in_snd,
  input  logic                              full,
  input  logic                              tbl_full,
  input  logic                              connected,
  output logic                              cts,
  output tcp_seq_pkg::seq_t                 loc_seq,
  output logic                              add_busy,
  output logic                              tbl_wr,
  output logic [tcp_tx_cfg_pkg::TBL_AW-1:0] tbl_addr,
  output tcp_seq_pkg::pkt_entry_t           tbl_entry
);

  logic                pend;      // segment open
  logic                snd_q;     // send strobe parked until the table has room
  tcp_seq_pkg::len_t   ctr;       // bytes already in open segment
  tcp_seq_pkg::len_t   n;         // bytes counting this cycle's byte
  logic [$clog2(tcp_tx_cfg_pkg::WAIT_TICKS+1)-1:0] idle;
  tcp_seq_pkg::seq_t   start;
  tcp_seq_pkg::seq_t   seg_start;
  tcp_seq_pkg::cks_t   cks;       // sum of complete words
  tcp_seq_pkg::cks_t   cks_n;
  tcp_seq_pkg::cks_t   close_cks;
  logic [7:0]          hi;        // high byte waiting for its partner
  logic [7:0]          hi_n;
  logic                idle_hit;
  logic                close;

  assign cts      = connected && !tbl_full && !full;
  assign add_busy = close; // entry write follows next cycle

  assign n         = ctr + tcp_seq_pkg::len_t'(in_val);
  assign seg_start = pend ? start : loc_seq; // first byte may arrive right now
  assign hi_n      = (in_val && !ctr[0]) ? in_dat : hi;
  assign cks_n     = (pend ? cks : '0) + ((in_val && ctr[0]) ? {16'h0, hi, in_dat} : '0);
  assign close_cks = n[0] ? cks_n + {16'h0, hi_n, 8'h00} : cks_n; // pad odd tail

  //////////////////////////////
  // close conditions
  //////////////////////////////

  assign idle_hit = pend && !in_val && (idle >= tcp_tx_cfg_pkg::WAIT_TICKS - 1);
  assign close = (pend || in_val) && !tbl_full &&
                 ((n == tcp_tx_cfg_pkg::MAX_PLD) || in_snd || snd_q || full || idle_hit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loc_seq  <= '0;
      pend     <= 1'b0;
      snd_q    <= 1'b0;
      ctr      <= '0;
      idle     <= '0;
      tbl_wr   <= 1'b0;
      tbl_addr <= '0;
    end else if (init) begin
      loc_seq  <= init_seq; // connection starts here
      pend     <= 1'b0;
      snd_q    <= 1'b0;
      ctr      <= '0;
      idle     <= '0;
      tbl_wr   <= 1'b0;
      tbl_addr <= '0;
    end else begin
      if (in_val) loc_seq <= loc_seq + 1'b1;
      tbl_wr <= close; // entry lands one cycle after close
      if (tbl_wr) tbl_addr <= tbl_addr + 1'b1;
      if (close) begin
        pend  <= 1'b0;
        snd_q <= 1'b0;
        ctr   <= '0;
        idle  <= '0;
      end else begin
        if (in_val) begin
          pend <= 1'b1;
          ctr  <= n;
          idle <= '0; // any byte restarts the idle count
        end else if (pend && idle != tcp_tx_cfg_pkg::WAIT_TICKS) begin
          idle <= idle + 1'b1; // saturates while the table is full
        end
        if (in_snd && (pend || in_val)) snd_q <= 1'b1;
      end
    end
  end

  // running sum and entry record
  always_ff @(posedge clk) begin
    if (!pend) start <= loc_seq;
    cks <= cks_n;
    hi  <= hi_n;
    if (close) begin
      tbl_entry <= '{exists: 1'b1, start: seg_start, stop: loc_seq + in_val, len: n,
                     cks: close_cks, tries: '0, rto: 16'(tcp_tx_cfg_pkg::RTO_SCANS)};
    end
  end

endmodule

/* hw/tcp_tx_buf.sv */
module tcp_tx_buf (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              init,
  input  logic                              wr,
  input  logic [7:0]                        wr_dat,
  input  tcp_seq_pkg::seq_t                 wr_seq,
  input  tcp_seq_pkg::seq_t                 free_ack,
  input  logic [tcp_tx_cfg_pkg::BUF_AW-1:0] rd_addr,
  output logic [7:0]                        rd_dat,
  output logic                              full
);

  logic [7:0]        mem [tcp_tx_cfg_pkg::BUF_DEPTH];
  tcp_seq_pkg::seq_t used_nxt; // bytes held once this cycle's write lands

  // everything from the last freed ack up to the write seq is still owed
  assign used_nxt = wr_seq + tcp_seq_pkg::seq_t'(wr) - free_ack;

  // ring addressed by low seq bits
  always_ff @(posedge clk) begin
    if (wr) mem[wr_seq[tcp_tx_cfg_pkg::BUF_AW-1:0]] <= wr_dat;
    rd_dat <= mem[rd_addr]; // one cycle read latency
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (init) begin
      full <= 1'b0; // new connection, ring empty
    end else begin
      full <= used_nxt >= tcp_tx_cfg_pkg::BUF_DEPTH;
    end
  end

  // cts must have held the user off, else unacked bytes get overwritten
  a_no_wr_full: assert property (
    @(posedge clk) disable iff (!rst_n || init) full |-> !wr
  );

endmodule

/* hw/tcp_tx_cfg_pkg.sv */
package tcp_tx_cfg_pkg;

  //////////////////////////////
  // storage geometry
  //////////////////////////////

  localparam int BUF_AW    = 8;           // byte ring address bits
  localparam int BUF_DEPTH = 1 << BUF_AW; // bytes in ring
  localparam int TBL_AW    = 2;           // packet table address bits
  localparam int TBL_DEPTH = 1 << TBL_AW; // 4 segments in flight

  //////////////////////////////
  // segmentation and timers
  //////////////////////////////

  localparam int MAX_PLD    = 16; // payload bytes per segment
  localparam int WAIT_TICKS = 8;  // idle cycles that close an open segment

  // timer counts scanner visits of one entry, not clock cycles
  localparam int RTO_SCANS = 40;
  localparam int RTX_TRIES = 3; // sends before the connection is dropped

endpackage

/* hw/tcp_seq_pkg.sv */
package tcp_seq_pkg;

  //////////////////////////////
  // sequence space
  //////////////////////////////

  typedef logic [31:0] seq_t; // wraps, order by sign of a - b
  typedef logic [15:0] len_t; // payload bytes
  typedef logic [31:0] cks_t; // unfolded sum of big-endian 16-bit words

  //////////////////////////////
  // packet table record
  //////////////////////////////

  // one segment held for (re)transmission
  typedef struct packed {
    logic        exists; // slot holds a live segment
    seq_t        start;  // seq of first byte
    seq_t        stop;   // seq after last byte, i.e. the ack that frees it
    len_t        len;    // stop - start
    cks_t        cks;    // odd tail byte padded with zero low byte
    logic [2:0]  tries;  // transmissions so far
    logic [15:0] rto;    // scanner visits since last send
  } pkt_entry_t;

endpackage
